/* include/bank_macros.svh */
`ifndef BANK_MACROS_SVH
`define BANK_MACROS_SVH

// bank geometry
`define BANK_ADDR_W 14
`define BANK_DATA_W 8
`define BANK_DEPTH  (1 << `BANK_ADDR_W)  // 16384 bytes per bank

// arduino_databank codes
`define BANK_SRC 2'd0
`define BANK_KEY 2'd1
`define BANK_CMD 2'd2
`define BANK_DST 2'd3

// engine opcodes
`define OP_NOP      8'h00
`define OP_END      8'h01
`define OP_FILL_SRC 8'h02  // fill src with src[0]

`endif

/* src/bank_pkg.sv */
`include "bank_macros.svh"

package bank_pkg;

    typedef logic [`BANK_ADDR_W-1:0] bank_addr_t;
    typedef logic [`BANK_DATA_W-1:0] bank_data_t;
    typedef logic [1:0]              bank_sel_t;   // one of the four bank codes

    // host strobe transfer
    typedef enum logic [2:0] {
        HOST_IDLE,
        HOST_SETUP,
        HOST_ACCESS,
        HOST_CAPTURE,
        HOST_DONE,
        HOST_WAIT_LOW
    } host_state_t;

    // command engine sequencing
    typedef enum logic [3:0] {
        ENG_IDLE,
        ENG_FETCH,
        ENG_FETCH_WAIT,
        ENG_DECODE,
        ENG_FILL_READ,
        ENG_FILL_READ_WAIT,
        ENG_FILL_WRITE,
        ENG_NEXT,
        ENG_HALT
    } engine_state_t;

endpackage

/* src/bank_ram.sv */
`timescale 1ns/1ps
`include "bank_macros.svh"

module bank_ram #(
    parameter int DUAL_PORT = 0
) (
    input  logic                 sysclk,
    input  logic                 a_en,
    input  logic                 a_we,
    input  bank_pkg::bank_addr_t a_addr,
    input  bank_pkg::bank_data_t a_wdata,
    input  logic                 b_en,
    input  logic                 b_we,
    input  bank_pkg::bank_addr_t b_addr,
    input  bank_pkg::bank_data_t b_wdata,
    output bank_pkg::bank_data_t a_rdata,
    output bank_pkg::bank_data_t b_rdata
);
    import bank_pkg::*;

    bank_data_t mem [`BANK_DEPTH];

    // host side read, old data on a same-cycle write
    always_ff @(posedge sysclk) begin
        if (a_en) begin
            a_rdata <= mem[a_addr];
        end
    end

    generate
        if (DUAL_PORT != 0) begin : g_dual
            always_ff @(posedge sysclk) begin
                if (a_en && a_we) begin
                    mem[a_addr] <= a_wdata;
                end
                if (b_en && b_we) begin
                    mem[b_addr] <= b_wdata;
                end
                if (b_en) begin
                    b_rdata <= mem[b_addr];  // engine side read
                end
            end

            // host and engine are not arbitrated against each other
            a_no_write_clash: assert property (@(posedge sysclk)
                !(a_en && a_we && b_en && b_we && (a_addr == b_addr)))
                else $error("bank_ram: both ports write address %h", a_addr);
        end else begin : g_single
            always_ff @(posedge sysclk) begin
                if (a_en && a_we) begin
                    mem[a_addr] <= a_wdata;
                end
            end

            assign b_rdata = '0;  // no engine port on this bank
        end
    endgenerate

endmodule

/* src/host_port.sv */
`timescale 1ns/1ps
`include "bank_macros.svh"

module host_port (
    input  logic                 sysclk,
    input  logic                 arduino_reset,
    input  logic                 arduino_clock,
    input  logic                 arduino_readwrite,
    input  bank_pkg::bank_sel_t  arduino_databank,
    input  bank_pkg::bank_data_t arduino_datain,
    input  bank_pkg::bank_data_t src_rdata,
    input  bank_pkg::bank_data_t key_rdata,
    input  bank_pkg::bank_data_t cmd_rdata,
    input  bank_pkg::bank_data_t dst_rdata,
    output bank_pkg::bank_data_t arduino_dataout,
    output logic [3:0]           host_en,
    output logic                 host_we,
    output bank_pkg::bank_addr_t host_addr,
    output bank_pkg::bank_data_t host_wdata
);
    import bank_pkg::*;

    host_state_t state;
    bank_sel_t   bank_q;           // bank latched at setup
    logic        write_q;          // 1 = write transfer
    bank_data_t  wdata_q;
    bank_addr_t  addr_cnt [4];     // one auto-increment address per bank
    bank_data_t  rd_byte;

    // read data of the latched bank
    always_comb begin
        case (bank_q)
            `BANK_SRC: rd_byte = src_rdata;
            `BANK_KEY: rd_byte = key_rdata;
            `BANK_CMD: rd_byte = cmd_rdata;
            default:   rd_byte = dst_rdata;
        endcase
    end

    assign host_en    = (state == HOST_ACCESS) ? (4'b0001 << bank_q) : 4'b0000;
    assign host_we    = (state == HOST_ACCESS) && write_q;
    assign host_addr  = addr_cnt[bank_q];
    assign host_wdata = wdata_q;

    always_ff @(posedge sysclk) begin
        if (arduino_reset) begin
            state           <= HOST_IDLE;
            bank_q          <= `BANK_SRC;
            write_q         <= 1'b0;
            arduino_dataout <= '0;
            for (int i = 0; i < 4; i++) begin
                addr_cnt[i] <= '0;
            end
        end else begin
            case (state)
                HOST_IDLE: begin
                    if (arduino_clock) begin
                        state <= HOST_SETUP;
                    end
                end

                // bank, direction and byte are sampled once per strobe
                HOST_SETUP: begin
                    bank_q  <= arduino_databank;
                    write_q <= arduino_readwrite;
                    wdata_q <= arduino_datain;
                    state   <= HOST_ACCESS;
                end

                HOST_ACCESS: begin
                    state <= HOST_CAPTURE;  // memory registers the read here
                end

                HOST_CAPTURE: begin
                    if (!write_q) begin
                        arduino_dataout <= rd_byte;  // held until the next read
                    end
                    state <= HOST_DONE;
                end

                HOST_DONE: begin
                    addr_cnt[bank_q] <= addr_cnt[bank_q] + 1'b1;
                    state            <= HOST_WAIT_LOW;
                end

                // one transfer per strobe level
                HOST_WAIT_LOW: begin
                    if (!arduino_clock) begin
                        state <= HOST_IDLE;
                    end
                end

                default: state <= HOST_IDLE;
            endcase
        end
    end

    // only one bank is touched per access
    a_host_en_onehot: assert property (@(posedge sysclk) disable iff (arduino_reset)
        $onehot0(host_en))
        else $error("host_port: host_en not one-hot, %b", host_en);

    a_host_we_with_en: assert property (@(posedge sysclk) disable iff (arduino_reset)
        host_we |-> (host_en != 4'b0000))
        else $error("host_port: host_we without a bank enable");

endmodule

/* src/command_engine.sv */
`timescale 1ns/1ps
`include "bank_macros.svh"

module command_engine (
    input  logic                 sysclk,
    input  logic                 arduino_reset,
    input  logic                 arduino_execute,
    input  bank_pkg::bank_data_t cmd_rdata,
    input  bank_pkg::bank_data_t src_rdata,
    output logic                 arduino_isfinished,
    output logic                 cmd_en,
    output bank_pkg::bank_addr_t cmd_addr,
    output logic                 src_en,
    output logic                 src_we,
    output bank_pkg::bank_addr_t src_addr,
    output bank_pkg::bank_data_t src_wdata
);
    import bank_pkg::*;

    engine_state_t state;
    bank_addr_t    pc;             // next opcode in cmd
    bank_data_t    fill_byte;
    bank_addr_t    fill_addr;
    bank_addr_t    fill_addr_nxt;

    assign fill_addr_nxt = fill_addr + 1'b1;

    // cmd bank port b
    assign cmd_en   = (state == ENG_FETCH);
    assign cmd_addr = pc;

    // src bank port b, address 0 holds the fill pattern
    assign src_en    = (state == ENG_FILL_READ) || (state == ENG_FILL_WRITE);
    assign src_we    = (state == ENG_FILL_WRITE);
    assign src_addr  = (state == ENG_FILL_WRITE) ? fill_addr : '0;
    assign src_wdata = fill_byte;

    always_ff @(posedge sysclk) begin
        if (arduino_reset) begin
            state              <= ENG_IDLE;
            pc                 <= '0;
            fill_addr          <= '0;
            arduino_isfinished <= 1'b0;
        end else begin
            case (state)
                ENG_IDLE: begin
                    if (arduino_execute) begin
                        state <= ENG_FETCH;
                    end
                end

                ENG_FETCH: begin
                    state <= ENG_FETCH_WAIT;
                end

                ENG_FETCH_WAIT: begin
                    state <= ENG_DECODE;  // opcode valid on cmd_rdata now
                end

                // cmd_rdata holds while cmd_en stays low
                ENG_DECODE: begin
                    case (cmd_rdata)
                        `OP_NOP: begin
                            state <= ENG_NEXT;
                        end
                        `OP_END: begin
                            arduino_isfinished <= 1'b1;
                            state              <= ENG_HALT;
                        end
                        `OP_FILL_SRC: begin
                            state <= ENG_FILL_READ;
                        end
                        default: begin
                            state <= ENG_NEXT;  // unknown opcode skipped
                        end
                    endcase
                end

                ENG_FILL_READ: begin
                    state <= ENG_FILL_READ_WAIT;
                end

                ENG_FILL_READ_WAIT: begin
                    fill_byte <= src_rdata;
                    fill_addr <= '0;
                    state     <= ENG_FILL_WRITE;
                end

                // one location per cycle, done once the address wraps
                ENG_FILL_WRITE: begin
                    fill_addr <= fill_addr_nxt;
                    if (fill_addr_nxt == '0) begin
                        state <= ENG_NEXT;
                    end
                end

                ENG_NEXT: begin
                    pc    <= pc + 1'b1;
                    state <= ENG_FETCH;
                end

                ENG_HALT: begin
                    state <= ENG_HALT;  // only reset leaves here
                end

                default: state <= ENG_IDLE;
            endcase
        end
    end

    // finished is sticky until the next reset
    a_finished_sticky: assert property (@(posedge sysclk) disable iff (arduino_reset)
        arduino_isfinished |=> arduino_isfinished)
        else $error("command_engine: arduino_isfinished dropped without reset");

endmodule

/* src/bank_top.sv */
`timescale 1ns/1ps
`include "bank_macros.svh"

module bank_top (
    input  logic                 sysclk,
    input  bank_pkg::bank_data_t arduino_datain,
    output bank_pkg::bank_data_t arduino_dataout,
    input  bank_pkg::bank_sel_t  arduino_databank,
    input  logic                 arduino_readwrite,
    input  logic                 arduino_clock,
    input  logic                 arduino_reset,
    input  logic                 arduino_execute,
    output logic                 arduino_isfinished
);
    import bank_pkg::*;

    // host side, shared by all four banks
    logic [3:0] host_en;
    logic       host_we;
    bank_addr_t host_addr;
    bank_data_t host_wdata;
    bank_data_t src_rdata_a;
    bank_data_t key_rdata_a;
    bank_data_t cmd_rdata_a;
    bank_data_t dst_rdata_a;

    // engine side
    logic       cmd_en_b;
    bank_addr_t cmd_addr_b;
    bank_data_t cmd_rdata_b;
    logic       src_en_b;
    logic       src_we_b;
    bank_addr_t src_addr_b;
    bank_data_t src_wdata_b;
    bank_data_t src_rdata_b;

    host_port u_host_port (
        .sysclk            (sysclk),
        .arduino_reset     (arduino_reset),
        .arduino_clock     (arduino_clock),
        .arduino_readwrite (arduino_readwrite),
        .arduino_databank  (arduino_databank),
        .arduino_datain    (arduino_datain),
        .src_rdata         (src_rdata_a),
        .key_rdata         (key_rdata_a),
        .cmd_rdata         (cmd_rdata_a),
        .dst_rdata         (dst_rdata_a),
        .arduino_dataout   (arduino_dataout),
        .host_en           (host_en),
        .host_we           (host_we),
        .host_addr         (host_addr),
        .host_wdata        (host_wdata)
    );

    command_engine u_command_engine (
        .sysclk             (sysclk),
        .arduino_reset      (arduino_reset),
        .arduino_execute    (arduino_execute),
        .cmd_rdata          (cmd_rdata_b),
        .src_rdata          (src_rdata_b),
        .arduino_isfinished (arduino_isfinished),
        .cmd_en             (cmd_en_b),
        .cmd_addr           (cmd_addr_b),
        .src_en             (src_en_b),
        .src_we             (src_we_b),
        .src_addr           (src_addr_b),
        .src_wdata          (src_wdata_b)
    );

    // src and cmd are also seen by the engine
    bank_ram #(.DUAL_PORT(1)) u_bank_src (
        .sysclk (sysclk),
        .a_en   (host_en[`BANK_SRC]),
        .a_we   (host_we),
        .a_addr (host_addr),
        .a_wdata(host_wdata),
        .b_en   (src_en_b),
        .b_we   (src_we_b),
        .b_addr (src_addr_b),
        .b_wdata(src_wdata_b),
        .a_rdata(src_rdata_a),
        .b_rdata(src_rdata_b)
    );

    bank_ram #(.DUAL_PORT(0)) u_bank_key (
        .sysclk (sysclk),
        .a_en   (host_en[`BANK_KEY]),
        .a_we   (host_we),
        .a_addr (host_addr),
        .a_wdata(host_wdata),
        .b_en   (1'b0),
        .b_we   (1'b0),
        .b_addr ('0),
        .b_wdata('0),
        .a_rdata(key_rdata_a),
        .b_rdata()
    );

    bank_ram #(.DUAL_PORT(1)) u_bank_cmd (
        .sysclk (sysclk),
        .a_en   (host_en[`BANK_CMD]),
        .a_we   (host_we),
        .a_addr (host_addr),
        .a_wdata(host_wdata),
        .b_en   (cmd_en_b),
        .b_we   (1'b0),         // engine only reads opcodes
        .b_addr (cmd_addr_b),
        .b_wdata('0),
        .a_rdata(cmd_rdata_a),
        .b_rdata(cmd_rdata_b)
    );

    bank_ram #(.DUAL_PORT(0)) u_bank_dst (
        .sysclk (sysclk),
        .a_en   (host_en[`BANK_DST]),
        .a_we   (host_we),
        .a_addr (host_addr),
        .a_wdata(host_wdata),
        .b_en   (1'b0),
        .b_we   (1'b0),
        .b_addr ('0),
        .b_wdata('0),
        .a_rdata(dst_rdata_a),
        .b_rdata()
    );

endmodule

/* dv/tb_bank_top.sv */
`timescale 1ns/1ps
`include "bank_macros.svh"

module tb_bank_top;
    import bank_pkg::*;

    localparam logic [31:0] SEED   = 32'h77e7b13a;
    localparam int WORDS           = 32;            // bytes per bank in the readback test
    localparam int FILL_CHECK      = 64;            // src bytes read after the fill
    localparam int RESET_CYCLES    = 16;
    localparam int STROBE_HIGH     = 12;
    localparam int STROBE_LOW      = 4;
    localparam int HOLD_CYCLES     = 200;
    localparam int END_LIMIT       = 50;            // fetch plus decode of one opcode
    localparam int FILL_LIMIT      = 32800;
    localparam int TRANSFERS       = 4 * WORDS * 2 + 1 + 5 + FILL_CHECK + 2 * WORDS;

    // summed test lengths plus margin
    localparam int WATCHDOG_CYCLES = TRANSFERS * (STROBE_HIGH + STROBE_LOW)
                                   + 6 * (RESET_CYCLES + 2) + END_LIMIT + HOLD_CYCLES
                                   + FILL_LIMIT + 20000;

    logic       sysclk            = 1'b0;
    logic       arduino_reset     = 1'b1;
    logic       arduino_clock     = 1'b0;
    logic       arduino_readwrite = 1'b0;
    logic       arduino_execute   = 1'b0;
    bank_sel_t  arduino_databank  = `BANK_SRC;
    bank_data_t arduino_datain    = '0;
    bank_data_t arduino_dataout;
    logic       arduino_isfinished;

    bank_data_t model [4][WORDS];   // expected contents of the first bytes of each bank
    bank_data_t fill_byte;
    int         error_count  = 0;
    int         errors_before = 0;
    int         tests_run    = 0;
    int         tests_failed = 0;

    bank_top DUT (
        .sysclk             (sysclk),
        .arduino_datain     (arduino_datain),
        .arduino_dataout    (arduino_dataout),
        .arduino_databank   (arduino_databank),
        .arduino_readwrite  (arduino_readwrite),
        .arduino_clock      (arduino_clock),
        .arduino_reset      (arduino_reset),
        .arduino_execute    (arduino_execute),
        .arduino_isfinished (arduino_isfinished)
    );

    always #20 sysclk = ~sysclk;  // 40 ns period

    task automatic apply_reset();
        arduino_reset <= 1'b1;
        repeat (RESET_CYCLES) @(posedge sysclk);
        arduino_reset <= 1'b0;
        @(posedge sysclk);
    endtask

    // one host transfer of 12 cycles high then 4 low
    task automatic strobe(input bank_sel_t bank, input logic is_write, input bank_data_t data);
        arduino_databank  <= bank;
        arduino_readwrite <= is_write;
        arduino_datain    <= data;
        arduino_clock     <= 1'b1;
        repeat (STROBE_HIGH) @(posedge sysclk);
        arduino_clock <= 1'b0;
        repeat (STROBE_LOW) @(posedge sysclk);
    endtask

    task automatic host_write(input bank_sel_t bank, input bank_data_t data);
        strobe(bank, 1'b1, data);
    endtask

    task automatic host_read(input bank_sel_t bank, output bank_data_t data);
        strobe(bank, 1'b0, '0);
        data = arduino_dataout;  // settled since the capture state
    endtask

    task automatic check_byte(input string sig, input string where,
                              input bank_data_t got, input bank_data_t exp);
        assert (got == exp)
            else begin
                $display("ERROR %s %s: got 0x%02h, expected 0x%02h", sig, where, got, exp);
                error_count++;
            end
    endtask

    task automatic pulse_execute();
        arduino_execute <= 1'b1;
        @(posedge sysclk);
        arduino_execute <= 1'b0;
    endtask

    task automatic wait_finished(input int limit);
        int waited;
        waited = 0;
        while (!arduino_isfinished && waited < limit) begin
            @(posedge sysclk);
            waited++;
        end
        assert (arduino_isfinished)
            else begin
                $display("engine did not raise arduino_isfinished within %0d cycles", limit);
                error_count++;
            end
    endtask

    task automatic end_test(input string name);
        int errs;
        errs = error_count - errors_before;
        tests_run++;
        if (errs == 0) begin
            $display("test %0d %s: pass", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: fail with %0d errors", tests_run, name, errs);
        end
        errors_before = error_count;
    endtask

    initial begin
        bank_data_t got;
        void'($urandom(SEED));

        apply_reset();
        check_byte("arduino_isfinished", "after reset", {7'b0, arduino_isfinished}, 8'h00);
        check_byte("arduino_dataout", "after reset", arduino_dataout, 8'h00);
        end_test("reset values");

        // banks interleaved on write and read back one bank at a time
        for (int i = 0; i < WORDS; i++) begin
            for (int b = 0; b < 4; b++) begin
                model[b][i] = bank_data_t'($urandom);
                host_write(bank_sel_t'(b), model[b][i]);
            end
        end
        apply_reset();
        for (int b = 0; b < 4; b++) begin
            for (int i = 0; i < WORDS; i++) begin
                host_read(bank_sel_t'(b), got);
                check_byte("arduino_dataout", $sformatf("bank %0d addr %0d", b, i),
                           got, model[b][i]);
            end
        end
        end_test("bank readback");

        apply_reset();
        host_write(`BANK_CMD, `OP_END);
        pulse_execute();
        wait_finished(END_LIMIT);
        repeat (HOLD_CYCLES) begin
            @(posedge sysclk);
            check_byte("arduino_isfinished", "hold after end", {7'b0, arduino_isfinished}, 8'h01);
        end
        end_test("end opcode");

        // nop, unknown opcode, fill, end
        apply_reset();
        host_write(`BANK_CMD, `OP_NOP);
        host_write(`BANK_CMD, 8'h7f);
        host_write(`BANK_CMD, `OP_FILL_SRC);
        host_write(`BANK_CMD, `OP_END);
        fill_byte = bank_data_t'($urandom);
        host_write(`BANK_SRC, fill_byte);
        pulse_execute();
        wait_finished(FILL_LIMIT);
        apply_reset();
        for (int i = 0; i < FILL_CHECK; i++) begin
            host_read(`BANK_SRC, got);
            check_byte("arduino_dataout", $sformatf("src addr %0d", i), got, fill_byte);
        end
        end_test("fill src");

        // key and dst untouched by the fill
        for (int i = 0; i < WORDS; i++) begin
            host_read(`BANK_KEY, got);
            check_byte("arduino_dataout", $sformatf("key addr %0d", i), got, model[`BANK_KEY][i]);
        end
        for (int i = 0; i < WORDS; i++) begin
            host_read(`BANK_DST, got);
            check_byte("arduino_dataout", $sformatf("dst addr %0d", i), got, model[`BANK_DST][i]);
        end
        end_test("other banks kept");

        $display("summary: %0d tests, %0d failed, %0d check errors",
                 tests_run, tests_failed, error_count);
        if (error_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge sysclk);
        $display("watchdog expired after %0d cycles, run did not complete", WATCHDOG_CYCLES);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

/* sources.f */
+incdir+include
src/bank_pkg.sv
src/bank_ram.sv
src/host_port.sv
src/command_engine.sv
src/bank_top.sv
dv/tb_bank_top.sv

/* run_sim.sh */
#!/bin/sh
# build and run the bank testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal \
        -f sources.f --top-module tb_bank_top -o Vtb_bank_top; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vtb_bank_top 2>&1)
sim_status=$?
echo "$sim_out"

if [ "$sim_status" -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "ALL CHECKS PASSED"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1
